//--- verilog/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// data and address width.
`define XLEN 32

// alu operation codes.
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_XOR   4'd4
`define ALU_SLL   4'd5
`define ALU_SRL   4'd6
`define ALU_SRA   4'd7
`define ALU_SLT   4'd8
`define ALU_SLTU  4'd9
`define ALU_EQ    4'd10
`define ALU_PASS2 4'd11

// immediate kinds.
`define IMM_I 2'd0
`define IMM_U 2'd1
`define IMM_J 2'd2
`define IMM_Z 2'd3

// operand 1 sources, code 3 is unused.
`define SRC1_RS1  2'd0
`define SRC1_PC   2'd1
`define SRC1_ZERO 2'd2

// operand 2 sources.
`define SRC2_IMM  2'd0
`define SRC2_RS2  2'd1
`define SRC2_CSR  2'd2
`define SRC2_ZERO 2'd3

`endif

//--- verilog/exec_pkg.sv
`include "exec_settings.svh"

package exec_pkg;

    // 12-bit field in the low bits.
    typedef struct packed {
        logic [19:0] pad;
        logic [11:0] imm12;
    } imm_i_view_t;

    // 20-bit field in the low bits.
    typedef struct packed {
        logic [11:0] pad;
        logic [19:0] imm20;
    } imm_u_view_t;

    // 5-bit field, csr immediates.
    typedef struct packed {
        logic [26:0] pad;
        logic [4:0]  imm5;
    } imm_z_view_t;

    // one immediate word as the decoder hands it over.
    // the same bits are read as a short or a long field
    // depending on the immediate kind.
    typedef union packed {
        logic [`XLEN-1:0] raw;
        imm_i_view_t      i_view;
        imm_u_view_t      u_view;
        imm_z_view_t      z_view;
    } imm_word_t;

endpackage

//--- verilog/imm_expand.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module imm_expand (
    input  exec_pkg::imm_word_t imm,
    input  logic [1:0]          kind,
    output logic [`XLEN-1:0]    value
);

    logic [11:0] field_i;
    logic [19:0] field_u;
    logic [4:0]  field_z;

    assign field_i = imm.i_view.imm12;
    assign field_u = imm.u_view.imm20;
    assign field_z = imm.z_view.imm5;

    always_comb begin
        case (kind)
            `IMM_I: begin
                value = {{20{field_i[11]}}, field_i};
            end
            `IMM_U: begin
                value = {field_u, 12'd0};
            end
            `IMM_J: begin
                // sign bit 31 drops out with the shift.
                value = {{11{field_u[19]}}, field_u, 1'b0};
            end
            `IMM_Z: begin
                value = {27'd0, field_z};
            end
        endcase
    end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module alu (
    input  logic [3:0]       op,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic [`XLEN-1:0] y
);

    logic [4:0] shamt;
    logic       less_signed;
    logic       less_unsigned;
    logic       equal;

    assign shamt = b[4:0];
    assign less_signed = $signed(a) < $signed(b);
    assign less_unsigned = a < b;
    assign equal = a == b;

    always_comb begin
        case (op)
            `ALU_ADD: begin
                y = a + b;
            end
            `ALU_SUB: begin
                y = a - b;
            end
            `ALU_AND: begin
                y = a & b;
            end
            `ALU_OR: begin
                y = a | b;
            end
            `ALU_XOR: begin
                y = a ^ b;
            end
            `ALU_SLL: begin
                y = a << shamt;
            end
            `ALU_SRL: begin
                y = a >> shamt;
            end
            `ALU_SRA: begin
                y = $signed(a) >>> shamt;
            end
            // compares land in bit 0.
            `ALU_SLT: begin
                y = {{(`XLEN-1){1'b0}}, less_signed};
            end
            `ALU_SLTU: begin
                y = {{(`XLEN-1){1'b0}}, less_unsigned};
            end
            `ALU_EQ: begin
                y = {{(`XLEN-1){1'b0}}, equal};
            end
            `ALU_PASS2: begin
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

//--- verilog/exec_stage.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_stage (
    input  logic                clock,
    input  logic                reset,
    input  logic                valid_in,
    input  logic                flush,
    input  logic                ready_out,
    input  logic [`XLEN-1:0]    inst,
    input  logic [`XLEN-1:0]    pc,
    input  exec_pkg::imm_word_t imm,
    input  logic [1:0]          imm_kind,
    input  logic [3:0]          alu_op,
    input  logic                invert,
    input  logic [1:0]          src1_sel,
    input  logic [1:0]          src2_sel,
    input  logic [`XLEN-1:0]    rs1_value,
    input  logic [`XLEN-1:0]    rs2_value,
    input  logic [`XLEN-1:0]    csr_value,
    input  logic [4:0]          rd,
    input  logic [2:0]          funct3,
    input  logic                reg_wen,
    input  logic                mem_wen,
    input  logic                mem_ren,
    input  logic [3:0]          csr_wen,
    input  logic                jump,
    input  logic                branch,
    output logic                ready_in,
    output logic                valid_out,
    output logic [`XLEN-1:0]    inst_out,
    output logic [`XLEN-1:0]    pc_out,
    output exec_pkg::imm_word_t imm_out,
    output logic [4:0]          rd_out,
    output logic [2:0]          funct3_out,
    output logic [`XLEN-1:0]    rs2_out,
    output logic [`XLEN-1:0]    csr_out,
    output logic                reg_wen_out,
    output logic                mem_wen_out,
    output logic                mem_ren_out,
    output logic [3:0]          csr_wen_out,
    output logic                jump_out,
    output logic                branch_out,
    output logic [`XLEN-1:0]    result,
    output logic [`XLEN-1:0]    exec_count
);

    logic             accept;
    logic [1:0]       imm_kind_q;
    logic [3:0]       alu_op_q;
    logic             invert_q;
    logic [1:0]       src1_sel_q;
    logic [1:0]       src2_sel_q;
    logic [`XLEN-1:0] rs1_q;
    logic [`XLEN-1:0] imm_value;
    logic [`XLEN-1:0] operand1;
    logic [`XLEN-1:0] operand2;
    logic [`XLEN-1:0] alu_y;

    // take a new one when empty or when the held one leaves.
    assign ready_in = ready_out | ~valid_out;
    assign accept = valid_in & ready_in;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else if (accept) begin
            valid_out <= ~flush;
        end else if (ready_out) begin
            valid_out <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            pc_out     <= pc;
            imm_out    <= imm;
            rd_out     <= rd;
            funct3_out <= funct3;
            rs2_out    <= rs2_value;
            csr_out    <= csr_value;
            imm_kind_q <= imm_kind;
            alu_op_q   <= alu_op;
            invert_q   <= invert;
            src1_sel_q <= src1_sel;
            src2_sel_q <= src2_sel;
            rs1_q      <= rs1_value;
        end
    end

    // side effects of a flushed instruction are dropped.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            reg_wen_out <= 1'b0;
            mem_wen_out <= 1'b0;
            mem_ren_out <= 1'b0;
            csr_wen_out <= 4'd0;
            jump_out    <= 1'b0;
            branch_out  <= 1'b0;
        end else if (accept) begin
            reg_wen_out <= reg_wen & ~flush;
            mem_wen_out <= mem_wen & ~flush;
            mem_ren_out <= mem_ren & ~flush;
            csr_wen_out <= flush ? 4'd0 : csr_wen;
            jump_out    <= jump & ~flush;
            branch_out  <= branch & ~flush;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            inst_out <= '0;
        end else if (flush) begin
            inst_out <= '0;
        end else if (accept) begin
            inst_out <= inst;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            exec_count <= '0;
        end else if (accept) begin
            exec_count <= exec_count + 32'd1;
        end
    end

    imm_expand u_imm_expand (
        .imm   (imm_out),
        .kind  (imm_kind_q),
        .value (imm_value)
    );

    always_comb begin
        case (src1_sel_q)
            `SRC1_RS1: operand1 = rs1_q;
            `SRC1_PC:  operand1 = pc_out;
            default:   operand1 = '0;
        endcase
    end

    always_comb begin
        case (src2_sel_q)
            `SRC2_IMM:  operand2 = imm_value;
            `SRC2_RS2:  operand2 = rs2_out;
            `SRC2_CSR:  operand2 = csr_out;
            `SRC2_ZERO: operand2 = '0;
        endcase
    end

    alu u_alu (
        .op (alu_op_q),
        .a  (operand1),
        .b  (operand2),
        .y  (alu_y)
    );

    // bne and bge come from eq and slt this way.
    assign result = alu_y ^ {{(`XLEN-1){1'b0}}, invert_q};

    a_flush_no_valid: assert property (
        @(posedge clock) disable iff (reset)
        accept && flush |=> !valid_out
    );

    // inst_out is the one output a flush may clear during a stall.
    a_hold_stable: assert property (
        @(posedge clock) disable iff (reset)
        valid_out && !ready_out |=> valid_out && $stable(pc_out) && $stable(imm_out)
            && $stable(rd_out) && $stable(funct3_out) && $stable(rs2_out)
            && $stable(csr_out) && $stable(reg_wen_out) && $stable(mem_wen_out)
            && $stable(mem_ren_out) && $stable(csr_wen_out) && $stable(jump_out)
            && $stable(branch_out) && $stable(result)
            && ($stable(inst_out) || $past(flush))
    );

    a_src1_code: assert property (
        @(posedge clock) disable iff (reset)
        accept |-> src1_sel inside {`SRC1_RS1, `SRC1_PC, `SRC1_ZERO}
    );

endmodule

//--- verilog/branch_resolve.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module branch_resolve (
    input  logic                valid_out,
    input  logic                jump,
    input  logic                branch,
    input  logic [`XLEN-1:0]    result,
    input  logic [`XLEN-1:0]    pc,
    input  exec_pkg::imm_word_t imm,
    output logic                redirect,
    output logic [`XLEN-1:0]    redirect_pc,
    output logic [`XLEN-1:0]    link_value
);

    logic [11:0]      offset_halfwords;
    logic [`XLEN-1:0] branch_offset;
    logic [`XLEN-1:0] branch_target;
    logic [`XLEN-1:0] jump_target;
    logic             taken;

    // b-type offset counts halfwords.
    assign offset_halfwords = imm.i_view.imm12;
    assign branch_offset = {{19{offset_halfwords[11]}}, offset_halfwords, 1'b0};
    assign branch_target = pc + branch_offset;

    // jalr target from the alu, low bit cleared.
    assign jump_target = {result[`XLEN-1:1], 1'b0};

    // bit 0 of the result is the compare outcome.
    assign taken = branch & result[0];

    assign redirect = valid_out & (jump | taken);
    assign redirect_pc = jump ? jump_target : branch_target;
    assign link_value = pc + 32'd4;

    // resolved after the delta cycles settle.
    always_comb begin
        a_one_kind: assert #0 (!(valid_out && jump && branch))
            else $error("jump and branch both set on a valid instruction");
    end

endmodule

//--- verilog/exec_top.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                valid_in,
    input  logic                flush,
    input  logic                ready_out,
    input  logic [`XLEN-1:0]    inst,
    input  logic [`XLEN-1:0]    pc,
    input  exec_pkg::imm_word_t imm,
    input  logic [1:0]          imm_kind,
    input  logic [3:0]          alu_op,
    input  logic                invert,
    input  logic [1:0]          src1_sel,
    input  logic [1:0]          src2_sel,
    input  logic [`XLEN-1:0]    rs1_value,
    input  logic [`XLEN-1:0]    rs2_value,
    input  logic [`XLEN-1:0]    csr_value,
    input  logic [4:0]          rd,
    input  logic [2:0]          funct3,
    input  logic                reg_wen,
    input  logic                mem_wen,
    input  logic                mem_ren,
    input  logic [3:0]          csr_wen,
    input  logic                jump,
    input  logic                branch,
    output logic                ready_in,
    output logic                valid_out,
    output logic [`XLEN-1:0]    inst_out,
    output logic [`XLEN-1:0]    pc_out,
    output exec_pkg::imm_word_t imm_out,
    output logic [4:0]          rd_out,
    output logic [2:0]          funct3_out,
    output logic [`XLEN-1:0]    rs2_out,
    output logic [`XLEN-1:0]    csr_out,
    output logic                reg_wen_out,
    output logic                mem_wen_out,
    output logic                mem_ren_out,
    output logic [3:0]          csr_wen_out,
    output logic                jump_out,
    output logic                branch_out,
    output logic [`XLEN-1:0]    result,
    output logic [`XLEN-1:0]    exec_count,
    output logic                redirect,
    output logic [`XLEN-1:0]    redirect_pc,
    output logic [`XLEN-1:0]    link_value
);

    exec_stage u_exec_stage (
        .clock       (clock),
        .reset       (reset),
        .valid_in    (valid_in),
        .flush       (flush),
        .ready_out   (ready_out),
        .inst        (inst),
        .pc          (pc),
        .imm         (imm),
        .imm_kind    (imm_kind),
        .alu_op      (alu_op),
        .invert      (invert),
        .src1_sel    (src1_sel),
        .src2_sel    (src2_sel),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .csr_value   (csr_value),
        .rd          (rd),
        .funct3      (funct3),
        .reg_wen     (reg_wen),
        .mem_wen     (mem_wen),
        .mem_ren     (mem_ren),
        .csr_wen     (csr_wen),
        .jump        (jump),
        .branch      (branch),
        .ready_in    (ready_in),
        .valid_out   (valid_out),
        .inst_out    (inst_out),
        .pc_out      (pc_out),
        .imm_out     (imm_out),
        .rd_out      (rd_out),
        .funct3_out  (funct3_out),
        .rs2_out     (rs2_out),
        .csr_out     (csr_out),
        .reg_wen_out (reg_wen_out),
        .mem_wen_out (mem_wen_out),
        .mem_ren_out (mem_ren_out),
        .csr_wen_out (csr_wen_out),
        .jump_out    (jump_out),
        .branch_out  (branch_out),
        .result      (result),
        .exec_count  (exec_count)
    );

    // resolver works on the registered stage outputs.
    branch_resolve u_branch_resolve (
        .valid_out   (valid_out),
        .jump        (jump_out),
        .branch      (branch_out),
        .result      (result),
        .pc          (pc_out),
        .imm         (imm_out),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .link_value  (link_value)
    );

endmodule

//--- bench/exec_tb.sv
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_tb;

    localparam int N_ALU = 200;
    localparam int N_STALL = 150;
    localparam int N_FLUSH = 80;
    localparam int N_REDIRECT = 100;
    // a stalled issue takes about three cycles.
    localparam int STIM_CYCLES = 4 + N_ALU + 3 * (N_STALL + N_FLUSH) + N_REDIRECT + 40;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 100;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] csr;
        logic [1:0]  kind;
        logic [3:0]  op;
        logic        invert;
        logic [1:0]  src1;
        logic [1:0]  src2;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        logic        jump;
        logic        branch;
    } instr_t;

    logic clock;
    logic reset;
    logic valid_in;
    logic flush;
    logic ready_out;
    logic [31:0] inst;
    logic [31:0] pc;
    exec_pkg::imm_word_t imm;
    logic [1:0] imm_kind;
    logic [3:0] alu_op;
    logic invert;
    logic [1:0] src1_sel;
    logic [1:0] src2_sel;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] csr_value;
    logic [4:0] rd;
    logic [2:0] funct3;
    logic reg_wen;
    logic mem_wen;
    logic mem_ren;
    logic [3:0] csr_wen;
    logic jump;
    logic branch;
    logic ready_in;
    logic valid_out;
    logic [31:0] inst_out;
    logic [31:0] pc_out;
    exec_pkg::imm_word_t imm_out;
    logic [4:0] rd_out;
    logic [2:0] funct3_out;
    logic [31:0] rs2_out;
    logic [31:0] csr_out;
    logic reg_wen_out;
    logic mem_wen_out;
    logic mem_ren_out;
    logic [3:0] csr_wen_out;
    logic jump_out;
    logic branch_out;
    logic [31:0] result;
    logic [31:0] exec_count;
    logic redirect;
    logic [31:0] redirect_pc;
    logic [31:0] link_value;

    logic [15:0] lfsr_state = 16'd66;
    logic stall_mode;
    int cycle_count;
    int error_count;
    int tests_passed;
    int tests_failed;
    int issued_total;
    int kept_total;
    int delivered_total;

    // reference state, one entry while the stage holds an instruction.
    instr_t held_q[$];
    instr_t exp_head;
    logic exp_valid;
    logic model_accept;
    logic [31:0] exp_inst;
    logic [31:0] exp_count;
    logic [31:0] exp_result;
    logic [8:0] exp_enables;
    logic exp_redirect;
    logic [31:0] exp_redirect_pc;

    exec_top UUT (.*);

    always #20 clock = ~clock;

    // fibonacci lfsr, taps 16 14 13 11.
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [31:0] expand_immediate(input logic [31:0] word,
                                                      input logic [1:0] kind);
        case (kind)
            `IMM_I: return 32'($signed(word[11:0]));
            `IMM_U: return {word[19:0], 12'd0};
            `IMM_J: return 32'($signed(word[19:0])) << 1;
            default: return {27'd0, word[4:0]};
        endcase
    endfunction

    function automatic logic [31:0] model_result(input instr_t r);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] y;
        a = (r.src1 == `SRC1_RS1) ? r.rs1 : (r.src1 == `SRC1_PC) ? r.pc : 32'd0;
        case (r.src2)
            `SRC2_IMM: b = expand_immediate(r.imm, r.kind);
            `SRC2_RS2: b = r.rs2;
            `SRC2_CSR: b = r.csr;
            default: b = 32'd0;
        endcase
        case (r.op)
            `ALU_ADD: y = a + b;
            `ALU_SUB: y = a - b;
            `ALU_AND: y = a & b;
            `ALU_OR: y = a | b;
            `ALU_XOR: y = a ^ b;
            `ALU_SLL: y = a << b[4:0];
            `ALU_SRL: y = a >> b[4:0];
            `ALU_SRA: y = $signed(a) >>> b[4:0];
            `ALU_SLT: y = {31'd0, $signed(a) < $signed(b)};
            `ALU_SLTU: y = {31'd0, a < b};
            `ALU_EQ: y = {31'd0, a == b};
            `ALU_PASS2: y = b;
            default: y = 32'd0;
        endcase
        y[0] = y[0] ^ r.invert;
        return y;
    endfunction

    function automatic instr_t current_record();
        instr_t r;
        r.pc = pc;
        r.imm = imm.raw;
        r.rs1 = rs1_value;
        r.rs2 = rs2_value;
        r.csr = csr_value;
        r.kind = imm_kind;
        r.op = alu_op;
        r.invert = invert;
        r.src1 = src1_sel;
        r.src2 = src2_sel;
        r.rd = rd;
        r.funct3 = funct3;
        r.jump = jump;
        r.branch = branch;
        return r;
    endfunction

    always @(posedge clock or posedge reset) begin
        if (reset) begin
            held_q.delete();
            exp_inst = '0;
            exp_count = '0;
            exp_enables = '0;
        end else begin
            model_accept = valid_in && (ready_out || held_q.size() == 0);
            // items that actually left the stage.
            if (valid_out && ready_out) begin
                delivered_total++;
            end
            if (ready_out && held_q.size() != 0) begin
                void'(held_q.pop_front());
            end
            if (flush) begin
                exp_inst = '0;
            end else if (model_accept) begin
                exp_inst = inst;
            end
            if (model_accept) begin
                exp_count = exp_count + 32'd1;
                exp_enables = flush ? 9'd0
                    : {reg_wen, mem_wen, mem_ren, csr_wen, jump, branch};
                if (!flush) begin
                    held_q.push_back(current_record());
                end
            end
        end
        exp_valid = held_q.size() != 0;
        if (exp_valid) begin
            exp_head = held_q[0];
            exp_result = model_result(exp_head);
        end
        exp_redirect = exp_valid && (exp_head.jump || (exp_head.branch && exp_result[0]));
        exp_redirect_pc = exp_head.jump ? {exp_result[31:1], 1'b0}
            : exp_head.pc + (32'($signed(exp_head.imm[11:0])) << 1);
    end

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("** Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("failure at time %0t: %s", $time, what);
    endtask

    // checks sample at the falling edge, away from every change.
    a_reset_state: assert property (@(negedge clock) reset |-> !valid_out && ready_in
            && !redirect && exec_count == '0 && {reg_wen_out, mem_wen_out, mem_ren_out,
            csr_wen_out, jump_out, branch_out} == 9'd0)
        else report_failure("outputs are not at their reset values during reset");
    a_valid: assert property (@(negedge clock) disable iff (reset) valid_out == exp_valid)
        else report_mismatch("valid_out", 32'(exp_valid), 32'(valid_out));
    a_ready: assert property (@(negedge clock) disable iff (reset)
            ready_in == (ready_out || !exp_valid))
        else report_mismatch("ready_in", 32'(ready_out || !exp_valid), 32'(ready_in));
    a_result: assert property (@(negedge clock) disable iff (reset)
            exp_valid |-> result == exp_result)
        else report_mismatch("result", exp_result, result);
    a_pc: assert property (@(negedge clock) disable iff (reset)
            exp_valid |-> pc_out == exp_head.pc)
        else report_mismatch("pc_out", exp_head.pc, pc_out);
    a_imm: assert property (@(negedge clock) disable iff (reset)
            exp_valid |-> imm_out.raw == exp_head.imm)
        else report_mismatch("imm_out", exp_head.imm, imm_out.raw);
    a_rs2: assert property (@(negedge clock) disable iff (reset)
            exp_valid |-> rs2_out == exp_head.rs2)
        else report_mismatch("rs2_out", exp_head.rs2, rs2_out);
    a_csr: assert property (@(negedge clock) disable iff (reset)
            exp_valid |-> csr_out == exp_head.csr)
        else report_mismatch("csr_out", exp_head.csr, csr_out);
    a_fields: assert property (@(negedge clock) disable iff (reset)
            exp_valid |-> {rd_out, funct3_out} == {exp_head.rd, exp_head.funct3})
        else report_mismatch("rd_out/funct3_out", 32'({exp_head.rd, exp_head.funct3}),
            32'({rd_out, funct3_out}));
    a_inst: assert property (@(negedge clock) disable iff (reset) inst_out == exp_inst)
        else report_mismatch("inst_out", exp_inst, inst_out);
    a_enables: assert property (@(negedge clock) disable iff (reset)
            {reg_wen_out, mem_wen_out, mem_ren_out, csr_wen_out, jump_out, branch_out}
            == exp_enables)
        else report_mismatch("enables", 32'(exp_enables), 32'({reg_wen_out, mem_wen_out,
            mem_ren_out, csr_wen_out, jump_out, branch_out}));
    a_count: assert property (@(negedge clock) disable iff (reset) exec_count == exp_count)
        else report_mismatch("exec_count", exp_count, exec_count);
    a_redirect: assert property (@(negedge clock) disable iff (reset)
            redirect == exp_redirect)
        else report_mismatch("redirect", 32'(exp_redirect), 32'(redirect));
    a_redirect_pc: assert property (@(negedge clock) disable iff (reset)
            exp_redirect |-> redirect_pc == exp_redirect_pc)
        else report_mismatch("redirect_pc", exp_redirect_pc, redirect_pc);
    a_link: assert property (@(negedge clock) disable iff (reset)
            exp_valid |-> link_value == exp_head.pc + 32'd4)
        else report_mismatch("link_value", exp_head.pc + 32'd4, link_value);
    a_hold: assert property (@(negedge clock) disable iff (reset)
            valid_out && !ready_out |=> valid_out && $stable(result) && $stable(pc_out)
            && $stable(imm_out) && $stable(rs2_out) && $stable(csr_out)
            && $stable({reg_wen_out, mem_wen_out, mem_ren_out, csr_wen_out})
            && $stable({jump_out, branch_out, redirect, redirect_pc}))
        else report_failure("outputs changed while the stage was stalled");
    a_stall_ready: assert property (@(negedge clock) disable iff (reset)
            valid_out && !ready_out |-> !ready_in)
        else report_failure("ready_in was high while a held instruction was stalled");
    a_flush_bubble: assert property (@(negedge clock) disable iff (reset)
            valid_in && ready_in && flush |=> !valid_out)
        else report_failure("a flushed instruction reached valid_out");

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #2;
        ready_out = stall_mode ? (random_bits(1) != 0) : 1'b1;
    endtask

    task automatic randomize_fields();
        logic [1:0] pick;
        inst = random_bits(32);
        pc = random_bits(30) << 2;
        imm.raw = random_bits(32);
        imm_kind = 2'(random_bits(2));
        alu_op = 4'(random_bits(4));
        invert = random_bits(1) != 0;
        pick = 2'(random_bits(2));
        src1_sel = (pick == 2'd3) ? `SRC1_ZERO : pick;
        src2_sel = 2'(random_bits(2));
        rs1_value = random_bits(32);
        rs2_value = random_bits(32);
        csr_value = random_bits(32);
        rd = 5'(random_bits(5));
        funct3 = 3'(random_bits(3));
        reg_wen = random_bits(1) != 0;
        mem_wen = random_bits(1) != 0;
        mem_ren = random_bits(1) != 0;
        csr_wen = 4'(random_bits(4));
        pick = 2'(random_bits(2));
        jump = pick == 2'd1;
        branch = pick == 2'd2;
    endtask

    task automatic set_redirect_case();
        if (random_bits(1) != 0) begin
            // jalr shape, rs1 plus i immediate.
            alu_op = `ALU_ADD;
            src1_sel = `SRC1_RS1;
            src2_sel = `SRC2_IMM;
            imm_kind = `IMM_I;
            invert = 1'b0;
            jump = 1'b1;
            branch = 1'b0;
        end else begin
            alu_op = (random_bits(1) != 0) ? `ALU_EQ : `ALU_SLT;
            src1_sel = `SRC1_RS1;
            src2_sel = `SRC2_RS2;
            jump = 1'b0;
            branch = 1'b1;
            if (random_bits(1) != 0) begin
                rs2_value = rs1_value;
            end
        end
    endtask

    // holds valid_in until the stage takes the instruction.
    task automatic issue_instruction(input logic flush_bit);
        flush = flush_bit;
        valid_in = 1'b1;
        @(negedge clock);
        while (!ready_in) begin
            next_cycle();
            @(negedge clock);
        end
        next_cycle();
        valid_in = 1'b0;
        flush = 1'b0;
        issued_total++;
        if (!flush_bit) begin
            kept_total++;
        end
    endtask

    task automatic drain_stage();
        stall_mode = 1'b0;
        ready_out = 1'b1;
        repeat (3) next_cycle();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        int mark;
        clock = 1'b0;
        reset = 1'b1;
        valid_in = 1'b0;
        flush = 1'b0;
        ready_out = 1'b1;
        inst = '0;
        pc = '0;
        imm.raw = '0;
        imm_kind = '0;
        alu_op = '0;
        invert = 1'b0;
        src1_sel = '0;
        src2_sel = '0;
        rs1_value = '0;
        rs2_value = '0;
        csr_value = '0;
        rd = '0;
        funct3 = '0;
        reg_wen = 1'b0;
        mem_wen = 1'b0;
        mem_ren = 1'b0;
        csr_wen = '0;
        jump = 1'b0;
        branch = 1'b0;
        stall_mode = 1'b0;

        mark = error_count;
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;
        repeat (2) next_cycle();
        finish_test("reset state", mark);

        mark = error_count;
        for (int i = 0; i < N_ALU; i++) begin
            randomize_fields();
            issue_instruction(1'b0);
        end
        drain_stage();
        finish_test("alu and operand selection", mark);

        mark = error_count;
        stall_mode = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            randomize_fields();
            issue_instruction(1'b0);
        end
        drain_stage();
        a_in_order_once: assert (delivered_total == kept_total)
            else report_mismatch("delivered count", 32'(kept_total), 32'(delivered_total));
        finish_test("back-pressure", mark);

        mark = error_count;
        stall_mode = 1'b1;
        for (int i = 0; i < N_FLUSH; i++) begin
            randomize_fields();
            issue_instruction(random_bits(1) != 0);
        end
        drain_stage();
        finish_test("flush", mark);

        mark = error_count;
        for (int i = 0; i < N_REDIRECT; i++) begin
            randomize_fields();
            set_redirect_case();
            issue_instruction(1'b0);
        end
        drain_stage();
        finish_test("redirect", mark);

        mark = error_count;
        a_final_count: assert (exec_count == 32'(issued_total))
            else report_mismatch("exec_count", 32'(issued_total), exec_count);
        finish_test("counter", mark);

        $display("tests passed %0d, tests failed %0d, errors %0d",
            tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+verilog
verilog/exec_pkg.sv
verilog/imm_expand.sv
verilog/alu.sv
verilog/exec_stage.sv
verilog/branch_resolve.sv
verilog/exec_top.sv
bench/exec_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module exec_tb -f src.f

run: compile
	@out="$$(./obj_dir/Vexec_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
